//--- Makefile
# Verilator build and run for the clock-crossing mailbox

TOP = tb_mbox
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- common/fifo_wr_if.sv
/*
 * write port of the mailbox FIFO
 * push with data from the producer, ready and fill level back from the FIFO
 */

`timescale 1ns/100ps

interface fifo_wr_if;

  logic                             push;
  mbox_pkg::word_t                  data;
  logic                             ready;
  logic [mbox_pkg::DEPTH_W-1:0]     depth;

  // register slave side
  modport producer (
    output push,
    output data,
    input  ready,
    input  depth
  );

  // FIFO side
  modport fifo (
    input  push,
    input  data,
    output ready,
    output depth
  );

endinterface

//--- common/mbox_pkg.sv
/*
 * clock-crossing mailbox shared definitions
 * payload word, FIFO sizing, Wishbone register map and STATUS layout
 */

package mbox_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////////////////////

  // bus data and FIFO payload share one word
  typedef logic [31:0] word_t;

  // crossing FIFO entries deliberately kept off a power of two
  localparam int unsigned FIFO_DEPTH = 5;

  // fill level range 0 to FIFO_DEPTH
  localparam int unsigned DEPTH_W = 3;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 4;

  // byte offsets
  localparam logic [ADDR_W-1:0] ADDR_DATA   = 4'h0;
  localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h4;
  localparam logic [ADDR_W-1:0] ADDR_COUNT  = 4'h8;

  // full flag position in STATUS above the fill level bits
  localparam int unsigned STATUS_FULL_BIT = 8;

endpackage

//--- hw/fifo_async/fifo_async.sv
/*
 * asynchronous FIFO for the mailbox
 * Gray pointers crossed through two flops each way, write-side fill level,
 * valid/ready stream on the read clock
 */

`timescale 1ns/100ps

module fifo_async #(
  parameter int unsigned Depth = mbox_pkg::FIFO_DEPTH
) (
  // write domain
  input  logic            clk_wr_i,
  input  logic            rst_wr_ni,
  fifo_wr_if.fifo         wr_i,

  // read domain
  input  logic            clk_rd_i,
  input  logic            rst_rd_ni,
  output logic            rd_valid_o,
  input  logic            rd_ready_i,
  output mbox_pkg::word_t rd_data_o
);

  localparam int unsigned IdxW = $clog2(Depth);
  localparam int unsigned PtrW = IdxW + 1;

  typedef logic [mbox_pkg::DEPTH_W-1:0] fill_t;

  logic [PtrW-1:0] wptr_bin;
  logic [PtrW-1:0] wptr_gray;
  logic [PtrW-1:0] rptr_bin;
  logic [PtrW-1:0] rptr_gray;

  // write pointer seen on the read clock
  logic [PtrW-1:0] wptr_gray_q1;
  logic [PtrW-1:0] wptr_gray_q2;
  logic [PtrW-1:0] wptr_sync_bin;

  // read pointer seen on the write clock
  logic [PtrW-1:0] rptr_gray_q1;
  logic [PtrW-1:0] rptr_gray_q2;
  logic [PtrW-1:0] rptr_sync_bin;

  logic            wr_incr;
  logic            rd_incr;
  logic            full;
  logic            empty;
  logic [IdxW-1:0] w_idx;
  logic [IdxW-1:0] r_sync_idx;
  fill_t           fill;

  mbox_pkg::word_t mem [Depth];

  ////////////////////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////////////////////

  assign wr_incr = wr_i.push & wr_i.ready;
  assign rd_incr = rd_valid_o & rd_ready_i;

  gray_ptr #(
    .Depth (Depth)
  ) u_wptr (
    .clk_i  (clk_wr_i),
    .rst_ni (rst_wr_ni),
    .incr_i (wr_incr),
    .bin_o  (wptr_bin),
    .gray_o (wptr_gray)
  );

  gray_ptr #(
    .Depth (Depth)
  ) u_rptr (
    .clk_i  (clk_rd_i),
    .rst_ni (rst_rd_ni),
    .incr_i (rd_incr),
    .bin_o  (rptr_bin),
    .gray_o (rptr_gray)
  );

  ////////////////////////////////////////////////////////////////////////////
  // synchronizers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_rd_i or negedge rst_rd_ni) begin
    if (!rst_rd_ni) begin
      wptr_gray_q1 <= '0;
      wptr_gray_q2 <= '0;
    end else begin
      wptr_gray_q1 <= wptr_gray;
      wptr_gray_q2 <= wptr_gray_q1;
    end
  end

  always_ff @(posedge clk_wr_i or negedge rst_wr_ni) begin
    if (!rst_wr_ni) begin
      rptr_gray_q1 <= '0;
      rptr_gray_q2 <= '0;
    end else begin
      rptr_gray_q1 <= rptr_gray;
      rptr_gray_q2 <= rptr_gray_q1;
    end
  end

  // decode with the pointer's own reflected code
  assign wptr_sync_bin = u_wptr.gray2bin(wptr_gray_q2);
  assign rptr_sync_bin = u_rptr.gray2bin(rptr_gray_q2);

  ////////////////////////////////////////////////////////////////////////////
  // status
  ////////////////////////////////////////////////////////////////////////////

  // same index with the opposite wrap
  assign full = (wptr_bin[IdxW-1:0] == rptr_sync_bin[IdxW-1:0]) &&
                (wptr_bin[IdxW] != rptr_sync_bin[IdxW]);

  assign empty = (wptr_sync_bin == rptr_bin);

  assign w_idx      = wptr_bin[IdxW-1:0];
  assign r_sync_idx = rptr_sync_bin[IdxW-1:0];

  // write-side fill level stays pessimistic until reads cross over
  always_comb begin
    if (wptr_bin[IdxW] == rptr_sync_bin[IdxW]) begin
      fill = fill_t'(w_idx) - fill_t'(r_sync_idx);
    end else begin
      fill = fill_t'(Depth) - fill_t'(r_sync_idx) + fill_t'(w_idx);
    end
  end

  assign wr_i.ready = ~full;
  assign wr_i.depth = fill;

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr_i) begin
    if (wr_incr) begin
      mem[w_idx] <= wr_i.data;
    end
  end

  // head entry holds still until the read pointer moves
  assign rd_data_o  = mem[rptr_bin[IdxW-1:0]];
  assign rd_valid_o = ~empty;

endmodule

//--- hw/fifo_async/gray_ptr.sv
/*
 * wrapping FIFO pointer with binary and registered Gray copies
 * reflected Gray code keeps single-bit steps for any depth
 */

`timescale 1ns/100ps

module gray_ptr #(
  parameter  int unsigned Depth = mbox_pkg::FIFO_DEPTH,
  localparam int unsigned IdxW  = $clog2(Depth),
  localparam int unsigned PtrW  = IdxW + 1
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            incr_i,
  output logic [PtrW-1:0] bin_o,
  output logic [PtrW-1:0] gray_o
);

  localparam logic [IdxW-1:0] LastIdx = IdxW'(Depth - 1);

  logic [PtrW-1:0] bin_next;

  // count up with wrap bit clear, reflected (down) with it set
  function automatic logic [PtrW-1:0] bin2gray(input logic [PtrW-1:0] bin);
    logic [IdxW-1:0] idx;
    idx = bin[PtrW-1] ? (LastIdx - bin[IdxW-1:0]) : bin[IdxW-1:0];
    return {bin[PtrW-1], idx ^ (idx >> 1)};
  endfunction

  // inverse of bin2gray for the far side of the synchronizer
  function automatic logic [PtrW-1:0] gray2bin(input logic [PtrW-1:0] gray);
    logic [IdxW-1:0] idx;
    idx[IdxW-1] = gray[IdxW-1];
    for (int i = IdxW - 2; i >= 0; i--) begin
      idx[i] = idx[i+1] ^ gray[i];
    end
    if (gray[PtrW-1]) begin
      idx = LastIdx - idx;
    end
    return {gray[PtrW-1], idx};
  endfunction

  always_comb begin
    bin_next = bin_o;
    if (incr_i) begin
      if (bin_o[IdxW-1:0] == LastIdx) begin
        // wrap from the last slot back to index 0
        bin_next = {~bin_o[PtrW-1], {IdxW{1'b0}}};
      end else begin
        bin_next = bin_o + PtrW'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bin_o  <= '0;
      gray_o <= '0;
    end else begin
      bin_o  <= bin_next;
      gray_o <= bin2gray(bin_next);
    end
  end

endmodule

//--- hw/mbox_top.sv
/*
 * clock-crossing mailbox top level
 * Wishbone writes on the write clock, stream out on the read clock
 */

`timescale 1ns/100ps

module mbox_top (
  input  logic                          clk_wr_i,
  input  logic                          rst_wr_ni,
  input  logic                          clk_rd_i,
  input  logic                          rst_rd_ni,

  // Wishbone slave on the write clock
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [mbox_pkg::ADDR_W-1:0]   wb_adr_i,
  input  mbox_pkg::word_t               wb_dat_i,
  output mbox_pkg::word_t               wb_dat_o,
  output logic                          wb_ack_o,

  // stream out on the read clock
  output logic                          rd_valid_o,
  input  logic                          rd_ready_i,
  output mbox_pkg::word_t               rd_data_o
);

  fifo_wr_if u_wr_if ();

  wb_mbox_regs u_regs (
    .clk_wr_i  (clk_wr_i),
    .rst_wr_ni (rst_wr_ni),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .fifo_o    (u_wr_if.producer)
  );

  fifo_async #(
    .Depth (mbox_pkg::FIFO_DEPTH)
  ) u_fifo (
    .clk_wr_i   (clk_wr_i),
    .rst_wr_ni  (rst_wr_ni),
    .wr_i       (u_wr_if.fifo),
    .clk_rd_i   (clk_rd_i),
    .rst_rd_ni  (rst_rd_ni),
    .rd_valid_o (rd_valid_o),
    .rd_ready_i (rd_ready_i),
    .rd_data_o  (rd_data_o)
  );

endmodule

//--- hw/wb_mbox_regs.sv
/*
 * Wishbone classic slave for the mailbox
 * DATA pushes into the FIFO, STATUS and COUNT are read back,
 * ack is held off while the FIFO is full
 */

`timescale 1ns/100ps

module wb_mbox_regs (
  input  logic                          clk_wr_i,
  input  logic                          rst_wr_ni,

  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [mbox_pkg::ADDR_W-1:0]   wb_adr_i,
  input  mbox_pkg::word_t               wb_dat_i,
  output mbox_pkg::word_t               wb_dat_o,
  output logic                          wb_ack_o,

  fifo_wr_if.producer                   fifo_o
);

  logic            req;
  logic            data_wr;
  logic            push;
  logic            ack_d;
  logic            ack_q;
  mbox_pkg::word_t count_q;
  mbox_pkg::word_t status;
  mbox_pkg::word_t rdata;

  ////////////////////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////////////////////

  // mask stb in the ack cycle where it is still high
  assign req     = wb_cyc_i & wb_stb_i & ~ack_q;
  assign data_wr = req & wb_we_i & (wb_adr_i == mbox_pkg::ADDR_DATA);

  // push only with room and otherwise wait with the cycle open
  assign push  = data_wr & fifo_o.ready;
  assign ack_d = req & (~data_wr | fifo_o.ready);

  assign fifo_o.push = push;
  assign fifo_o.data = wb_dat_i;

  always_ff @(posedge clk_wr_i or negedge rst_wr_ni) begin
    if (!rst_wr_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  assign wb_ack_o = ack_q;

  // accepted words since reset
  always_ff @(posedge clk_wr_i or negedge rst_wr_ni) begin
    if (!rst_wr_ni) begin
      count_q <= '0;
    end else if (push) begin
      count_q <= count_q + 32'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    status = '0;
    status[mbox_pkg::DEPTH_W-1:0]       = fifo_o.depth;
    status[mbox_pkg::STATUS_FULL_BIT]   = ~fifo_o.ready;
  end

  always_comb begin
    case (wb_adr_i)
      mbox_pkg::ADDR_STATUS: rdata = status;
      mbox_pkg::ADDR_COUNT:  rdata = count_q;
      // DATA is write-only
      default:               rdata = '0;
    endcase
  end

  // captured with the request and valid alongside ack
  always_ff @(posedge clk_wr_i) begin
    if (req && !wb_we_i) begin
      wb_dat_o <= rdata;
    end
  end

endmodule

//--- src.f
common/mbox_pkg.sv
common/fifo_wr_if.sv
hw/fifo_async/gray_ptr.sv
hw/fifo_async/fifo_async.sv
hw/wb_mbox_regs.sv
hw/mbox_top.sv
verif/mbox_sva.sv
verif/tb_mbox.sv

//--- verif/mbox_sva.sv
/*
 * assertions on the mailbox FIFO
 * write handshake, stream hold and single-bit Gray pointer steps
 */

`timescale 1ns/100ps

module mbox_sva #(
  parameter int unsigned PtrW = 4
) (
  input logic            clk_wr_i,
  input logic            rst_wr_ni,
  input logic            clk_rd_i,
  input logic            rst_rd_ni,
  input logic            push_i,
  input logic            ready_i,
  input logic            rd_valid_i,
  input logic            rd_ready_i,
  input mbox_pkg::word_t rd_data_i,
  input logic [PtrW-1:0] wptr_gray_i,
  input logic [PtrW-1:0] rptr_gray_i
);

  // producer waits for room
  push_needs_ready: assert property (@(posedge clk_wr_i) disable iff (!rst_wr_ni)
    push_i |-> ready_i)
    else $error("push while the FIFO was full");

  // stalled head word holds still
  stream_hold: assert property (@(posedge clk_rd_i) disable iff (!rst_rd_ni)
    rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_data_i))
    else $error("stream word dropped or changed before its transfer");

  wptr_single_step: assert property (@(posedge clk_wr_i) disable iff (!rst_wr_ni)
    $countones(wptr_gray_i ^ $past(wptr_gray_i)) <= 1)
    else $error("write Gray pointer changed more than one bit");

  rptr_single_step: assert property (@(posedge clk_rd_i) disable iff (!rst_rd_ni)
    $countones(rptr_gray_i ^ $past(rptr_gray_i)) <= 1)
    else $error("read Gray pointer changed more than one bit");

endmodule

bind fifo_async mbox_sva #(
  .PtrW (PtrW)
) u_sva (
  .clk_wr_i    (clk_wr_i),
  .rst_wr_ni   (rst_wr_ni),
  .clk_rd_i    (clk_rd_i),
  .rst_rd_ni   (rst_rd_ni),
  .push_i      (wr_i.push),
  .ready_i     (wr_i.ready),
  .rd_valid_i  (rd_valid_o),
  .rd_ready_i  (rd_ready_i),
  .rd_data_i   (rd_data_o),
  .wptr_gray_i (wptr_gray),
  .rptr_gray_i (rptr_gray)
);

//--- verif/tb_mbox.sv
/*
 * testbench for the clock-crossing mailbox
 * Wishbone host on the write clock, random stream consumer on the read clock,
 * expected words from a reference model compared as they arrive
 */

`timescale 1ns/100ps

module tb_mbox;

  localparam mbox_pkg::word_t FULL_STATUS = mbox_pkg::word_t'(mbox_pkg::FIFO_DEPTH) |
                                            (32'd1 << mbox_pkg::STATUS_FULL_BIT);

  logic                        clk_wr;
  logic                        clk_rd;
  logic                        rst_wr_n;
  logic                        rst_rd_n;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [mbox_pkg::ADDR_W-1:0] wb_adr;
  mbox_pkg::word_t             wb_dat_w;
  mbox_pkg::word_t             wb_dat_r;
  logic                        wb_ack;
  logic                        rd_valid;
  logic                        rd_ready;
  mbox_pkg::word_t             rd_data;

  logic            hold_rd;
  integer          seed = 32'hd58c5a03;
  int              errors = 0;
  mbox_pkg::word_t seq;
  mbox_pkg::word_t exp_q[$];

  mbox_top dut (
    .clk_wr_i   (clk_wr),
    .rst_wr_ni  (rst_wr_n),
    .clk_rd_i   (clk_rd),
    .rst_rd_ni  (rst_rd_n),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .rd_valid_o (rd_valid),
    .rd_ready_i (rd_ready),
    .rd_data_o  (rd_data)
  );

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  initial begin
    clk_rd = 1'b0;
    forever #7 clk_rd = ~clk_rd;
  end

  // expected payload of the n-th accepted word
  function automatic mbox_pkg::word_t ref_word(input mbox_pkg::word_t n);
    return (n * 32'h9e37_79b1) ^ {n[15:0], 16'h5a3c};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone host
  ////////////////////////////////////////////////////////////////////////////

  task automatic wb_start(input logic we, input logic [mbox_pkg::ADDR_W-1:0] adr,
                          input mbox_pkg::word_t wdata);
    @(posedge clk_wr);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
  endtask

  task automatic wait_ack(input int max_cycles, output logic acked,
                          output mbox_pkg::word_t rdata);
    int n;
    n     = 0;
    acked = 1'b0;
    rdata = '0;
    while (!acked && n < max_cycles) begin
      @(posedge clk_wr);
      n++;
      if (wb_ack) begin
        acked = 1'b1;
        rdata = wb_dat_r;
      end
    end
  endtask

  // stb drops on the edge that showed ack
  task automatic wb_end();
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_access(input logic we, input logic [mbox_pkg::ADDR_W-1:0] adr,
                           input mbox_pkg::word_t wdata, input int max_cycles,
                           output logic acked, output mbox_pkg::word_t rdata);
    wb_start(we, adr, wdata);
    wait_ack(max_cycles, acked, rdata);
    wb_end();
    if (!acked) begin
      $display("no acknowledge for offset 0x%h within %0d cycles", adr, max_cycles);
      errors++;
    end
  endtask

  task automatic check_reg(input logic [mbox_pkg::ADDR_W-1:0] adr,
                           input mbox_pkg::word_t exp, input string what);
    logic            acked;
    mbox_pkg::word_t got;
    wb_access(1'b0, adr, '0, 50, acked, got);
    if (acked && got !== exp) begin
      $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // queue the word at ack before it can reach the stream
  task automatic send_word();
    logic            acked;
    mbox_pkg::word_t unused;
    wb_access(1'b1, mbox_pkg::ADDR_DATA, ref_word(seq), 200, acked, unused);
    if (acked) begin
      exp_q.push_back(ref_word(seq));
      seq++;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 2000) begin
      @(posedge clk_wr);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timed out with %0d words still expected on the stream", exp_q.size());
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stream side
  ////////////////////////////////////////////////////////////////////////////

  // random consumer that hold_rd parks with ready low
  initial begin : consumer
    integer rnd;
    rd_ready = 1'b0;
    forever begin
      @(posedge clk_rd);
      rnd = $random(seed);
      rd_ready <= ~hold_rd & rnd[0];
    end
  end

  initial begin : compare_stream
    mbox_pkg::word_t exp;
    forever begin
      @(posedge clk_rd);
      if (rst_rd_n && rd_valid && rd_ready) begin
        if (exp_q.size() == 0) begin
          $display("CHECK FAILED at %0t: stream word %h with none expected", $time, rd_data);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          if (rd_data !== exp) begin
            $display("CHECK FAILED at %0t: stream word %h, expected %h", $time, rd_data, exp);
            errors++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    mbox_pkg::word_t rdata;
    logic            acked;
    int              n;
    rst_wr_n = 1'b0;
    rst_rd_n = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    hold_rd  = 1'b0;
    seq      = '0;
    repeat (16) @(posedge clk_wr);
    rst_wr_n <= 1'b1;
    rst_rd_n <= 1'b1;
    @(posedge clk_wr);

    // reset state
    if (rd_valid !== 1'b0 || wb_ack !== 1'b0) begin
      $display("CHECK FAILED at %0t: valid %b ack %b after reset", $time, rd_valid, wb_ack);
      errors++;
    end
    check_reg(mbox_pkg::ADDR_STATUS, '0, "STATUS after reset");
    check_reg(mbox_pkg::ADDR_COUNT, '0, "COUNT after reset");

    // ordered delivery
    repeat (40) send_word();
    wait_drained();

    // back-pressure with the consumer parked
    hold_rd <= 1'b1;
    repeat (2) @(posedge clk_wr);
    repeat (mbox_pkg::FIFO_DEPTH) send_word();
    check_reg(mbox_pkg::ADDR_STATUS, FULL_STATUS, "STATUS when full");
    wb_start(1'b1, mbox_pkg::ADDR_DATA, ref_word(seq));
    wait_ack(20, acked, rdata);
    if (acked) begin
      $display("a DATA write was acknowledged while the FIFO was full");
      errors++;
    end else begin
      hold_rd <= 1'b0;
      wait_ack(200, acked, rdata);
      if (!acked) begin
        $display("the stalled DATA write never completed after the consumer resumed");
        errors++;
      end
    end
    wb_end();
    hold_rd <= 1'b0;
    if (acked) begin
      exp_q.push_back(ref_word(seq));
      seq++;
    end

    // draining
    wait_drained();
    n = 0;
    while (rd_valid && n < 20) begin
      @(posedge clk_rd);
      n++;
    end
    if (rd_valid) begin
      $display("rd_valid_o stayed high after the last word was taken");
      errors++;
    end
    // credit takes a few write edges to come back
    n = 0;
    rdata = 32'hffff_ffff;
    while (rdata !== '0 && n < 20) begin
      wb_access(1'b0, mbox_pkg::ADDR_STATUS, '0, 50, acked, rdata);
      n++;
    end
    if (rdata !== '0) begin
      $display("CHECK FAILED at %0t: STATUS after draining read %h, expected 0", $time, rdata);
      errors++;
    end

    // counter and writes to read-only registers
    check_reg(mbox_pkg::ADDR_COUNT, seq, "COUNT of accepted words");
    wb_access(1'b1, mbox_pkg::ADDR_STATUS, 32'hffff_ffff, 50, acked, rdata);
    wb_access(1'b1, mbox_pkg::ADDR_COUNT, '0, 50, acked, rdata);
    check_reg(mbox_pkg::ADDR_COUNT, seq, "COUNT after register writes");
    check_reg(mbox_pkg::ADDR_STATUS, '0, "STATUS after register writes");
    repeat (10) @(posedge clk_wr);
    if (rd_valid || exp_q.size() != 0) begin
      $display("a register write reached the stream");
      errors++;
    end

    $display("errors %0d, words accepted %0d, words unchecked %0d",
             errors, seq, exp_q.size());
    if (errors == 0 && exp_q.size() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
